// File: axi_fetch_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module axi_fetch_bridge import fetch_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       redirect_i,
    // request from pc generator
    input  logic       req_valid_i,
    input  fetch_req_t req_i,
    output logic       req_ready_o,
    // axi4-lite read address
    output logic       ar_valid_o,
    output axi_ar_t    ar_o,
    input  logic       ar_ready_i,
    // axi4-lite read data
    input  logic       r_valid_i,
    input  axi_r_t     r_i,
    output logic       r_ready_o,
    // response toward fetch queue
    output logic       rsp_valid_o,
    output fetch_rsp_t rsp_o,
    input  logic       rsp_ready_i
);

    // gray-ish encoding, one bit flips per step
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_AR   = 2'b01,    // address wait
        ST_R    = 2'b11,    // data wait
        ST_RSP  = 2'b10     // response hold
    } state_e;

    state_e           state_q, state_d;
    logic             stale_q;        // read abandoned by a redirect
    logic [`XLEN-1:0] addr_q;
    fetch_rsp_t       rsp_q;
    logic             req_fire;
    logic             r_fire;
    logic             busy;

    assign req_ready_o = (state_q == ST_IDLE);
    assign req_fire    = req_valid_i && req_ready_o;
    assign r_fire      = r_valid_i && r_ready_o;
    assign busy        = (state_q == ST_AR) || (state_q == ST_R);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (req_fire) state_d = ST_AR;
            ST_AR:   if (ar_ready_i) state_d = ST_R;
            ST_R: begin
                // stale data completes on the bus, then is dropped
                if (r_valid_i) state_d = (stale_q || redirect_i) ? ST_IDLE : ST_RSP;
            end
            ST_RSP:  if (rsp_ready_i || redirect_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    // stale flag
    // a request taken on the redirect edge carries an old pc
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            stale_q <= 1'b0;
        end else if (req_fire) begin
            stale_q <= redirect_i;
        end else if (r_fire) begin
            stale_q <= 1'b0;              // read retired
        end else if (redirect_i && busy) begin
            stale_q <= 1'b1;
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q <= req_i.pc;           // held for the whole ar phase
        end
        if (r_fire) begin
            rsp_q.pc      <= addr_q;
            rsp_q.instr   <= r_i.data;
            rsp_q.bus_err <= (r_i.resp != `AXI_RESP_OKAY);  // slverr / decerr
        end
    end

    assign ar_valid_o  = (state_q == ST_AR);
    assign ar_o.addr   = addr_q;
    assign ar_o.prot   = `AXI_PROT_INSTR;
    assign r_ready_o   = (state_q == ST_R);
    assign rsp_valid_o = (state_q == ST_RSP);
    assign rsp_o       = rsp_q;

    // axi rule: address payload frozen until accepted
    a_ar_stable: assert property (@(posedge clock) disable iff (!reset)
        (ar_valid_o && !ar_ready_i) |=> (ar_valid_o && $stable(ar_o)))
        else $error("bridge: ar payload changed before handshake");

    // one read in flight, never overlaps a held response
    a_one_outstanding: assert property (@(posedge clock) disable iff (!reset)
        !(rsp_valid_o && ar_valid_o))
        else $error("bridge: ar_valid while response held");

endmodule

`default_nettype wire

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and instruction width
`define XLEN 32

// first fetch address out of reset
`define RESET_PC 32'h8000_0000

// fetch queue entries, power of two only
`define FETCH_QUEUE_DEPTH 4

// arprot bit 2 = instruction, bit 1 = secure (0), bit 0 = unprivileged (0)
`define AXI_PROT_INSTR 3'b100

// rresp codes
`define AXI_RESP_OKAY 2'b00

`endif

// File: fetch_pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect_i,      // taken branch or trap
    input  logic [`XLEN-1:0] redirect_pc_i,
    output logic             req_valid_o,
    output fetch_req_t       req_o,
    input  logic             req_ready_i
);

    logic [`XLEN-1:0] pc_q;       // next address to fetch
    logic             valid_q;    // low only while in reset
    logic             req_fire;

    assign req_fire = req_valid_o && req_ready_i;

    // pc register
    // redirect wins over the sequential step
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;          // restart at new target
        end else if (req_fire) begin
            pc_q <= pc_q + 'd4;             // sequential, no compressed
        end
    end

    // valid comes up on the first edge after reset release
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    assign req_valid_o = valid_q;
    assign req_o.pc    = pc_q;   // offered continuously

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

`include "fetch_macros.svh"

    // pc generator -> bridge
    typedef struct packed {
        logic [`XLEN-1:0] pc;
    } fetch_req_t;

    // bridge -> queue -> predecoder
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        logic             bus_err;   // rresp was not okay
    } fetch_rsp_t;

    // axi4-lite read address payload
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [2:0]       prot;
    } axi_ar_t;

    // axi4-lite read data payload
    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic [1:0]       resp;
    } axi_r_t;

    typedef enum logic [3:0] {
        CLS_OP      = 4'd0,
        CLS_OP_IMM  = 4'd1,
        CLS_LOAD    = 4'd2,
        CLS_STORE   = 4'd3,
        CLS_BRANCH  = 4'd4,
        CLS_JAL     = 4'd5,
        CLS_JALR    = 4'd6,
        CLS_LUI     = 4'd7,
        CLS_AUIPC   = 4'd8,
        CLS_SYSTEM  = 4'd9,
        CLS_ILLEGAL = 4'd10,
        CLS_FAULT   = 4'd11   // bus error on fetch
    } instr_class_e;

    // handed to the decode stage
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        instr_class_e     cls;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [`XLEN-1:0] imm;     // sign-extended
    } decoded_t;

endpackage

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue import fetch_pkg::*; #(
    parameter type entry_t = fetch_rsp_t
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   flush_i,         // redirect, drop everything
    input  logic   push_valid_i,
    input  entry_t push_data_i,
    output logic   push_ready_o,
    output logic   pop_valid_o,
    output entry_t pop_data_o,
    input  logic   pop_ready_i
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);   // pointers wrap for free

    entry_t           mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;          // one extra bit to tell full
    logic             push_fire;
    logic             pop_fire;

    assign push_ready_o = (count_q != DEPTH[PTR_W:0]);
    assign pop_valid_o  = (count_q != '0);
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_valid_o && pop_ready_i;
    assign pop_data_o   = mem_q[rd_ptr_q];    // head entry

    // storage, no reset
    always_ff @(posedge clock) begin
        if (push_fire && !flush_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;                   // push and pop on this edge are lost
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_fire) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    // last entry popped with nothing pushed leaves the queue empty
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset)
        (pop_fire && !push_fire && !flush_i && count_q == 1) |=> !pop_valid_o)
        else $error("queue: pop from an empty queue");

    a_count_bound: assert property (@(posedge clock) disable iff (!reset)
        count_q <= DEPTH)
        else $error("queue: occupancy above depth");

endmodule

`default_nettype wire

// File: fetch_top.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
axi_fetch_bridge.sv
fetch_queue.sv
instr_predecode.sv
fetch_top.sv
tb_clock_gen.sv
fetch_top_tb.sv

// File: fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    // axi4-lite read port
    output logic             ar_valid_o,
    output axi_ar_t          ar_o,
    input  logic             ar_ready_i,
    input  logic             r_valid_i,
    input  axi_r_t           r_i,
    output logic             r_ready_o,
    // decode stage port
    output logic             dec_valid_o,
    output decoded_t         dec_o,
    input  logic             dec_ready_i
);

    logic       req_valid, req_ready;   // pc_gen -> bridge
    fetch_req_t req;
    logic       rsp_valid, rsp_ready;   // bridge -> queue
    fetch_rsp_t rsp;
    logic       q_valid, q_ready;       // queue -> predecoder
    fetch_rsp_t q_data;

    fetch_pc_gen pc_gen_inst (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .req_valid_o   (req_valid),
        .req_o         (req),
        .req_ready_i   (req_ready)
    );

    axi_fetch_bridge bridge_inst (
        .clock       (clock),
        .reset       (reset),
        .redirect_i  (redirect_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .ar_valid_o  (ar_valid_o),
        .ar_o        (ar_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_i         (r_i),
        .r_ready_o   (r_ready_o),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready)
    );

    fetch_queue #(
        .entry_t (fetch_rsp_t)
    ) queue_inst (
        .clock        (clock),
        .reset        (reset),
        .flush_i      (redirect_i),   // flush on redirect
        .push_valid_i (rsp_valid),
        .push_data_i  (rsp),
        .push_ready_o (rsp_ready),
        .pop_valid_o  (q_valid),
        .pop_data_o   (q_data),
        .pop_ready_i  (q_ready)
    );

    instr_predecode predecode_inst (
        .clock       (clock),
        .reset       (reset),
        .redirect_i  (redirect_i),
        .in_valid_i  (q_valid),
        .in_i        (q_data),
        .in_ready_o  (q_ready),
        .out_valid_o (dec_valid_o),
        .out_o       (dec_o),
        .out_ready_i (dec_ready_i)
    );

endmodule

`default_nettype wire

// File: fetch_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top_tb import fetch_pkg::*; ();

    localparam int NUM_DECODES = 2000;
    localparam int IDLE_LIMIT  = 200;     // cycles with no decode before giving up
    localparam int RESET_LIMIT = 50;
    localparam logic [31:0] ERR_LO = 32'h8000_0100;   // slverr window
    localparam logic [31:0] ERR_HI = 32'h8000_0140;

    logic        clock, reset;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        ar_valid, ar_ready;
    axi_ar_t     ar;
    logic        r_valid, r_ready;
    axi_r_t      r;
    logic        dec_valid, dec_ready;
    decoded_t    dec;

    logic        rd_busy;        // ar accepted, r not yet returned
    logic [31:0] rd_addr;
    int          ar_wait, r_wait;
    logic [31:0] mem_salt;       // per-seed field randomness
    logic [31:0] exp_pc;         // reference pc
    int          decoded, idle, n_fault, n_illegal;
    logic        ar_stalled, dec_stalled;
    axi_ar_t     ar_held;
    decoded_t    dec_held;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) clock_gen_inst (
        .clock_o (clock),
        .reset_o (reset)
    );

    fetch_top fetch_top_inst (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ar_valid_o    (ar_valid),
        .ar_o          (ar),
        .ar_ready_i    (ar_ready),
        .r_valid_i     (r_valid),
        .r_i           (r),
        .r_ready_o     (r_ready),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec),
        .dec_ready_i   (dec_ready)
    );

    task automatic show_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_on_error(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // scrambles the whole address
    function automatic logic [31:0] mix(input logic [31:0] a);
        logic [31:0] h;
        h = (a ^ mem_salt) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        return h ^ (h >> 13);
    endfunction

    // memory image: real opcodes, random fields, a few bad encodings
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        logic [6:0]  op;
        h = mix(a);
        case (h[3:0])
            4'd0:    op = 7'h33;
            4'd1:    op = 7'h13;
            4'd2:    op = 7'h03;
            4'd3:    op = 7'h23;
            4'd4:    op = 7'h63;
            4'd5:    op = 7'h6f;
            4'd6:    op = 7'h67;
            4'd7:    op = 7'h37;
            4'd8:    op = 7'h17;
            4'd9:    op = 7'h73;
            4'd10:   op = 7'h13;
            4'd11:   op = 7'h63;
            4'd12:   op = 7'h7f;              // reserved major opcode
            4'd13:   op = 7'h0b;              // custom-0
            4'd14:   op = {h[8:4], 2'b01};    // compressed form
            default: op = h[10:4];            // anything
        endcase
        return {h[31:7], op};
    endfunction

    function automatic logic in_err_range(input logic [31:0] a);
        return (a >= ERR_LO) && (a < ERR_HI);
    endfunction

    function automatic instr_class_e ref_class(input logic [31:0] w, input logic err);
        if (err) return CLS_FAULT;
        case (w[6:0])
            7'h33:   return CLS_OP;
            7'h13:   return CLS_OP_IMM;
            7'h03:   return CLS_LOAD;
            7'h23:   return CLS_STORE;
            7'h63:   return CLS_BRANCH;
            7'h6f:   return CLS_JAL;
            7'h67:   return CLS_JALR;
            7'h37:   return CLS_LUI;
            7'h17:   return CLS_AUIPC;
            7'h73:   return CLS_SYSTEM;
            default: return CLS_ILLEGAL;
        endcase
    endfunction

    // sign-extend the low bits of v
    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        logic signed [31:0] t;
        t = v << (32 - bits);
        return t >>> (32 - bits);
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w, input instr_class_e cls);
        case (cls)
            CLS_OP_IMM, CLS_LOAD, CLS_JALR: return sext({20'b0, w[31:20]}, 12);
            CLS_STORE:  return sext({20'b0, w[31:25], w[11:7]}, 12);
            CLS_BRANCH: return sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
            CLS_JAL:    return sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
            CLS_LUI, CLS_AUIPC: return {w[31:12], 12'h000};
            default:    return 32'h0;
        endcase
    endfunction

    task automatic check_decode();
        logic [31:0]  w;
        instr_class_e cls;
        w   = mem_word(exp_pc);
        cls = ref_class(w, in_err_range(exp_pc));
        assert (dec.pc == exp_pc) else show_mismatch("dec_o.pc", 128'(dec.pc), 128'(exp_pc));
        assert (dec.instr == w) else show_mismatch("dec_o.instr", 128'(dec.instr), 128'(w));
        assert (dec.cls == cls) else show_mismatch("dec_o.cls", 128'(dec.cls), 128'(cls));
        assert (dec.rd == w[11:7]) else show_mismatch("dec_o.rd", 128'(dec.rd), 128'(w[11:7]));
        assert (dec.rs1 == w[19:15])
            else show_mismatch("dec_o.rs1", 128'(dec.rs1), 128'(w[19:15]));
        assert (dec.rs2 == w[24:20])
            else show_mismatch("dec_o.rs2", 128'(dec.rs2), 128'(w[24:20]));
        assert (dec.imm == ref_imm(w, cls))
            else show_mismatch("dec_o.imm", 128'(dec.imm), 128'(ref_imm(w, cls)));
        if (cls == CLS_FAULT) n_fault++;
        if (cls == CLS_ILLEGAL) n_illegal++;
    endtask

    // sampled at the falling edge, handshakes land on the next rising edge
    task automatic check_cycle();
        if (ar_stalled) begin
            assert (ar_valid) else stop_on_error("ar_valid_o dropped before ar_ready_i");
            assert (ar == ar_held) else show_mismatch("ar_o", 128'(ar), 128'(ar_held));
        end
        if (dec_stalled) begin
            assert (dec_valid) else stop_on_error("dec_valid_o dropped while stalled");
            assert (dec == dec_held) else show_mismatch("dec_o", 128'(dec), 128'(dec_held));
        end
        if (rd_busy) begin
            assert (r_ready) else stop_on_error("r_ready_o low while a read is outstanding");
            assert (!ar_valid) else stop_on_error("second read issued while one is in flight");
        end
        if (ar_valid) begin
            assert (ar.prot == `AXI_PROT_INSTR)
                else show_mismatch("ar_o.prot", 128'(ar.prot), 128'(`AXI_PROT_INSTR));
        end
        ar_stalled  = ar_valid && !ar_ready;
        ar_held     = ar;
        dec_stalled = dec_valid && !dec_ready && !redirect;
        dec_held    = dec;
        if (ar_valid && ar_ready) begin
            rd_busy = 1'b1;
            rd_addr = ar.addr;
            r_wait  = $urandom_range(0, 3);
            ar_wait = $urandom_range(0, 3);   // for the next address
        end
        if (r_valid && r_ready) rd_busy = 1'b0;
        if (dec_valid && dec_ready) begin
            check_decode();
            exp_pc += 4;
            decoded++;
            idle = 0;
        end
        if (redirect) exp_pc = redirect_pc;   // new sequence from here
    endtask

    // 10 ns after the rising edge
    task automatic drive_inputs();
        ar_ready = 1'b0;
        if (ar_valid) begin
            if (ar_wait == 0) ar_ready = 1'b1;
            else ar_wait--;
        end
        r_valid = 1'b0;
        r       = '0;
        if (rd_busy) begin
            if (r_wait == 0) begin
                r_valid   = 1'b1;
                r.data    = mem_word(rd_addr);
                r.resp    = in_err_range(rd_addr) ? 2'b10 : `AXI_RESP_OKAY;  // slverr
            end else begin
                r_wait--;
            end
        end
        redirect    = (decoded > 0) && ($urandom_range(0, 39) == 0);
        redirect_pc = redirect ? (`RESET_PC + ($urandom_range(0, 255) << 2)) : 32'h0;
        dec_ready   = !redirect && ($urandom_range(0, 3) != 0);   // no take on redirect
    endtask

    initial begin
        int i;
        redirect    = 1'b0;
        redirect_pc = 32'h0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r           = '0;
        dec_ready   = 1'b0;
        void'($urandom(27366));
        mem_salt    = $urandom();
        ar_wait     = $urandom_range(0, 3);
        r_wait      = 0;
        rd_busy     = 1'b0;
        rd_addr     = 32'h0;
        exp_pc      = `RESET_PC;
        decoded     = 0;
        idle        = 0;
        n_fault     = 0;
        n_illegal   = 0;
        ar_stalled  = 1'b0;
        dec_stalled = 1'b0;
        ar_held     = '0;
        dec_held    = '0;

        i = 0;
        while (!reset && i < RESET_LIMIT) begin
            @(posedge clock);
            i++;
        end
        assert (reset) else stop_on_error("reset was never released");

        while (decoded < NUM_DECODES) begin
            @(posedge clock);
            #10;
            drive_inputs();
            @(negedge clock);
            check_cycle();
            idle++;
            assert (idle < IDLE_LIMIT) else stop_on_error("decode stream stopped, timeout");
        end

        // error window and bad opcodes both seen
        assert (n_fault > 0) else stop_on_error("no fetch fault was exercised");
        assert (n_illegal > 0) else stop_on_error("no illegal opcode was exercised");
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_predecode.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module instr_predecode import fetch_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       redirect_i,
    input  logic       in_valid_i,
    input  fetch_rsp_t in_i,
    output logic       in_ready_o,
    output logic       out_valid_o,
    output decoded_t   out_o,
    input  logic       out_ready_i
);

    decoded_t out_q;
    logic     valid_q;
    logic     load;

    // rv32i base opcode map, compressed not supported
    function automatic decoded_t predecode(input fetch_rsp_t rsp);
        decoded_t         d;
        logic [`XLEN-1:0] ins;
        ins     = rsp.instr;
        d.pc    = rsp.pc;
        d.instr = ins;
        d.rd    = ins[11:7];     // fixed fields, valid or not
        d.rs1   = ins[19:15];
        d.rs2   = ins[24:20];
        if (rsp.bus_err) begin
            d.cls = CLS_FAULT;
        end else if (ins[1:0] != 2'b11) begin
            d.cls = CLS_ILLEGAL;  // 16-bit encoding
        end else begin
            case (ins[6:2])
                5'b01100: d.cls = CLS_OP;
                5'b00100: d.cls = CLS_OP_IMM;
                5'b00000: d.cls = CLS_LOAD;
                5'b01000: d.cls = CLS_STORE;
                5'b11000: d.cls = CLS_BRANCH;
                5'b11011: d.cls = CLS_JAL;
                5'b11001: d.cls = CLS_JALR;
                5'b01101: d.cls = CLS_LUI;
                5'b00101: d.cls = CLS_AUIPC;
                5'b11100: d.cls = CLS_SYSTEM;
                default:  d.cls = CLS_ILLEGAL;
            endcase
        end
        case (d.cls)
            CLS_OP_IMM, CLS_LOAD, CLS_JALR: d.imm = {{20{ins[31]}}, ins[31:20]};
            CLS_STORE:  d.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            CLS_BRANCH: d.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            CLS_LUI, CLS_AUIPC: d.imm = {ins[31:12], 12'b0};
            CLS_JAL:    d.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:    d.imm = '0;   // r-type, system, illegal, fault
        endcase
        return d;
    endfunction

    // take a new entry when empty or when the current one leaves
    assign in_ready_o = !valid_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (redirect_i) begin
            valid_q <= 1'b0;            // wrong-path word
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) out_q <= predecode(in_i);
    end

    assign out_valid_o = valid_q;
    assign out_o       = out_q;

    // decode register frozen while the decode stage stalls
    a_out_hold: assert property (@(posedge clock) disable iff (!reset)
        (out_valid_o && !out_ready_i && !redirect_i) |=> (out_valid_o && $stable(out_o)))
        else $error("predecode: output changed while stalled");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the fetch front-end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_top.f \
    --top-module fetch_top_tb \
    -o fetch_top_tb

# nonzero exit on $fatal fails the script
./obj_dir/fetch_top_tb

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clock_o,
    output logic reset_o      // active low
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

    // release off the edge, like every other input
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #10 reset_o = 1'b1;
    end

endmodule

`default_nettype wire
